// File: list.f
+incdir+verilog
verilog/bpred_pkg.sv
verilog/ras.sv
verilog/btb.sv
verilog/next_pc_sel.sv
verilog/bpred_top.sv
sim/bpred_tb.sv

// File: Bender.yml
package:
  name: bpred

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bpred_pkg.sv
      - verilog/ras.sv
      - verilog/btb.sv
      - verilog/next_pc_sel.sv
      - verilog/bpred_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/bpred_tb.sv

// File: sim/bpred_tb.sv
`timescale 1ns/1ps

`include "bpred_cfg.svh"

module bpred_tb;

    import bpred_pkg::*;

    localparam int   WAIT_LIMIT  = 20;
    localparam int   RAND_CYCLES = 3000;
    // directed call / return sites, tag 0x40, index 0..10
    localparam pc_t  CALL_PC     = 32'h0000_1000;
    localparam pc_t  RET_PC      = 32'h0000_1020;
    localparam pc_t  CORET_PC    = 32'h0000_1024;
    localparam pc_t  CALL9_PC    = 32'h0000_1028;

    logic     CLK;
    logic     nRST;
    logic     fetch_valid;
    pc_t      fetch_pc;
    logic     resolve_valid;
    resolve_t resolve;
    logic     pred_valid;
    pred_t    pred;

    // reference state, btb and stack
    logic        m_valid [16];
    btb_tag_t    m_tag [16];
    br_kind_e    m_kind [16];
    pc_t         m_target [16];
    target_t     m_stack [`BPRED_RAS_ENTRIES];
    ras_idx_t    m_sp;
    logic [31:0] lfsr_q;

    bpred_top u_dut (
        .CLK           (CLK),
        .nRST          (nRST),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .pred_valid    (pred_valid),
        .pred          (pred)
    );

    always #10 CLK = ~CLK;

    // ------------------------------
    // random source
    // ------------------------------

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // 16 indices, 2 tags
    function automatic pc_t rand_pc();
        return 32'h8000_0000 | (rand_bits(1) << 6) | (rand_bits(4) << 2);
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------

    task automatic reset_model();
        for (int i = 0; i < 16; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_kind[i]   = BR_NONE;
            m_target[i] = '0;
        end
        for (int i = 0; i < `BPRED_RAS_ENTRIES; i++) begin
            m_stack[i] = '0;
        end
        m_sp = '0;
    endtask

    // expected prediction for one edge, then the edge's state update
    function automatic pred_t predict_ref(input logic fv, input pc_t pc,
                                          input logic rv, input resolve_t r);
        pred_t    p;
        int       i;
        br_kind_e k;
        pc_t      nxt;
        logic     psh;
        logic     pp;
        i   = pc[5:2];
        nxt = pc + 32'd4;
        k   = (m_valid[i] && (m_tag[i] == pc[13:6])) ? m_kind[i] : BR_NONE;
        p.taken   = (k != BR_NONE);
        p.ras_idx = m_sp;
        if (k == BR_JUMP || k == BR_CALL) begin
            p.target = m_target[i];
        end else if (k == BR_RET || k == BR_CORET) begin
            p.target = {m_stack[m_sp], 1'b0};
        end else begin
            p.target = nxt;
        end
        psh = fv && (k == BR_CALL || k == BR_CORET);
        pp  = fv && (k == BR_RET || k == BR_CORET);
        // restore first, fetch change dropped
        if (rv && r.mispredict) begin
            m_sp = r.ras_idx;
        end else if (psh && pp) begin
            m_stack[m_sp] = nxt[31:1];
        end else if (psh) begin
            m_sp          = m_sp + 1'b1;
            m_stack[m_sp] = nxt[31:1];
        end else if (pp) begin
            m_sp = m_sp - 1'b1;
        end
        // training, kind none leaves the slot empty
        if (rv) begin
            i           = r.pc[5:2];
            m_valid[i]  = (r.kind != BR_NONE);
            m_tag[i]    = r.pc[13:6];
            m_kind[i]   = r.kind;
            m_target[i] = {r.target[31:1], 1'b0};
        end
        return p;
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_taken(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_run($sformatf("FAILED at %0t ns: %s taken %b, expected %b",
                               $time, what, got, want));
        end
    endtask

    task automatic check_target(input pc_t got, input pc_t want, input string what);
        if (got !== want) begin
            stop_run($sformatf("FAILED at %0t ns: %s target %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    task automatic check_ras_idx(input ras_idx_t got, input ras_idx_t want,
                                 input string what);
        if (got !== want) begin
            stop_run($sformatf("FAILED at %0t ns: %s ras_idx %0d, expected %0d",
                               $time, what, got, want));
        end
    endtask

    // outputs settle at +1, inputs still those of the edge
    always @(posedge CLK) begin
        pred_t want;
        #1;
        if (nRST) begin
            want = predict_ref(fetch_valid, fetch_pc, resolve_valid, resolve);
            if (pred_valid !== fetch_valid) begin
                stop_run($sformatf("FAILED at %0t ns: pred_valid %b, fetch_valid was %b",
                                   $time, pred_valid, fetch_valid));
            end
            if (fetch_valid) begin
                check_taken(pred.taken, want.taken, "model");
                check_target(pred.target, want.target, "model");
                check_ras_idx(pred.ras_idx, want.ras_idx, "model");
            end
        end
    end

    // ------------------------------
    // drivers
    // ------------------------------

    // strobes last one cycle
    task automatic tick();
        @(posedge CLK);
        #2;
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
    endtask

    task automatic train(input pc_t pc, input pc_t tgt, input br_kind_e k);
        resolve_valid = 1'b1;
        resolve = '{pc: pc, target: tgt, kind: k, mispredict: 1'b0, ras_idx: '0};
        tick();
    endtask

    // mispredict resolve, lands with the next fetch
    task automatic arm_restore(input ras_idx_t idx);
        resolve_valid = 1'b1;
        resolve = '{pc: 32'h3030, target: 32'h3100, kind: BR_JUMP, mispredict: 1'b1,
                    ras_idx: idx};
    endtask

    task automatic fetch_once(input pc_t pc, output pred_t got);
        int waited;
        waited      = 0;
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        tick();
        while (!pred_valid) begin
            if (waited >= WAIT_LIMIT) begin
                stop_run("timed out waiting for pred_valid after a fetch");
            end else begin
                tick();
                waited++;
            end
        end
        got = pred;
    endtask

    task automatic expect_fetch(input pc_t pc, input logic taken, input pc_t tgt,
                                input ras_idx_t idx, input string what);
        pred_t got;
        fetch_once(pc, got);
        check_taken(got.taken, taken, what);
        check_target(got.target, tgt, what);
        check_ras_idx(got.ras_idx, idx, what);
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    initial begin
        ras_idx_t s;
        ras_idx_t sm1;
        logic [31:0] kv;
        CLK           = 1'b0;
        nRST          = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        lfsr_q        = 32'h30d33994;
        reset_model();
        repeat (5) @(posedge CLK);
        #2;
        nRST = 1'b1;

        // untrained, fall through
        expect_fetch(32'h0000_0100, 1'b0, 32'h0000_0104, 3'd0, "cold");
        expect_fetch(32'h8000_1230, 1'b0, 32'h8000_1234, 3'd0, "cold");

        // jump hit, other tag at same index misses
        train(32'h0000_0240, 32'h0000_1000, BR_JUMP);
        expect_fetch(32'h0000_0240, 1'b1, 32'h0000_1000, 3'd0, "jump hit");
        expect_fetch(32'h0000_0280, 1'b0, 32'h0000_0284, 3'd0, "tag miss");

        for (int i = 0; i < 8; i++) begin
            train(CALL_PC + 4 * i, 32'h0000_2000, BR_CALL);
        end
        train(RET_PC, 32'h0, BR_RET);
        train(CORET_PC, 32'h0, BR_CORET);
        train(CALL9_PC, 32'h0000_2000, BR_CALL);

        // depth 8, links come back in reverse
        for (int i = 0; i < 8; i++) begin
            expect_fetch(CALL_PC + 4 * i, 1'b1, 32'h0000_2000, ras_idx_t'(i), "call");
        end
        for (int j = 0; j < 8; j++) begin
            expect_fetch(RET_PC, 1'b1, CALL_PC + 4 * (7 - j) + 4, ras_idx_t'(8 - j),
                         "return");
        end

        // coret swaps the top in place
        expect_fetch(CALL_PC, 1'b1, 32'h0000_2000, 3'd0, "call");
        expect_fetch(CORET_PC, 1'b1, 32'h0000_1004, 3'd1, "coret");
        expect_fetch(RET_PC, 1'b1, 32'h0000_1028, 3'd1, "return after coret");

        // nine pushes, ninth lands on the first one's slot
        for (int i = 0; i < 8; i++) begin
            expect_fetch(CALL_PC + 4 * i, 1'b1, 32'h0000_2000, ras_idx_t'(i), "wrap call");
        end
        expect_fetch(CALL9_PC, 1'b1, 32'h0000_2000, 3'd0, "ninth call");
        for (int k = 0; k < 9; k++) begin
            s   = ras_idx_t'(1 - k);
            sm1 = s - 1'b1;
            expect_fetch(RET_PC, 1'b1, (s == 3'd1) ? 32'h0000_102C : 32'h0000_1004 + 4 * sm1,
                         s, "wrap return");
        end

        // restore wins over the same cycle's push and pop
        expect_fetch(CALL_PC, 1'b1, 32'h0000_2000, 3'd0, "call");
        expect_fetch(RET_PC, 1'b1, 32'h0000_1004, 3'd1, "return");
        arm_restore(3'd1);
        expect_fetch(CALL_PC + 12, 1'b1, 32'h0000_2000, 3'd0, "call under restore");
        expect_fetch(RET_PC, 1'b1, 32'h0000_1004, 3'd1, "top kept");
        arm_restore(3'd5);
        expect_fetch(RET_PC, 1'b1, 32'h0000_1020, 3'd0, "return under restore");
        expect_fetch(32'h0000_0100, 1'b0, 32'h0000_0104, 3'd5, "restored sp");

        // random mix, checked against the model every cycle
        for (int n = 0; n < RAND_CYCLES; n++) begin
            fetch_valid          = (rand_bits(2) != 0);
            fetch_pc             = rand_pc();
            resolve_valid        = (rand_bits(2) == 0);
            resolve.pc           = rand_pc();
            resolve.target       = rand_bits(16) << 1;
            kv                   = rand_bits(3);
            resolve.kind         = (kv < 5) ? br_kind_e'(kv[2:0]) : BR_CALL;
            resolve.mispredict   = (rand_bits(3) == 0);
            resolve.ras_idx      = ras_idx_t'(rand_bits(3));
            @(posedge CLK);
            #2;
        end
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        tick();
        tick();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog/bpred_top.sv
`timescale 1ns/1ps

module bpred_top (
    input  logic                CLK,
    input  logic                nRST,
    // fetch side
    input  logic                fetch_valid,
    input  bpred_pkg::pc_t      fetch_pc,
    // resolve side, trains btb and restores sp
    input  logic                resolve_valid,
    input  bpred_pkg::resolve_t resolve,
    // prediction, one cycle after fetch
    output logic                pred_valid,
    output bpred_pkg::pred_t    pred
);

    import bpred_pkg::*;

    // ------------------------------
    // internal wiring
    // ------------------------------

    btb_lookup_t lookup;
    target_t     ras_top;
    ras_idx_t    ras_sp;
    stack_ctl_t  ctl;
    // restore only on a wrong prediction
    logic        restore;

    assign restore = resolve_valid && resolve.mispredict;

    btb u_btb (
        .CLK       (CLK),
        .nRST      (nRST),
        .lookup_pc (fetch_pc),
        .lookup    (lookup),
        .wr_valid  (resolve_valid),
        .wr        (resolve)
    );

    ras u_ras (
        .CLK         (CLK),
        .nRST        (nRST),
        .ctl         (ctl),
        .restore     (restore),
        .restore_idx (resolve.ras_idx),
        .ras_top     (ras_top),
        .ras_sp      (ras_sp)
    );

    next_pc_sel u_next_pc_sel (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .lookup      (lookup),
        .ras_top     (ras_top),
        .ras_sp      (ras_sp),
        .ctl         (ctl),
        .pred_valid  (pred_valid),
        .pred        (pred)
    );

endmodule

// File: verilog/next_pc_sel.sv
`timescale 1ns/1ps

module next_pc_sel (
    input  logic                   CLK,
    input  logic                   nRST,
    // fetch strobe
    input  logic                   fetch_valid,
    input  bpred_pkg::pc_t         fetch_pc,
    // btb and stack views of this fetch
    input  bpred_pkg::btb_lookup_t lookup,
    input  bpred_pkg::target_t     ras_top,
    input  bpred_pkg::ras_idx_t    ras_sp,
    // stack update for this fetch
    output bpred_pkg::stack_ctl_t  ctl,
    // registered prediction
    output logic                   pred_valid,
    output bpred_pkg::pred_t       pred
);

    import bpred_pkg::*;

    pc_t   seq_pc;
    pred_t pred_d;

    // ------------------------------
    // target select
    // ------------------------------

    assign seq_pc = fetch_pc + 32'd4;

    always_comb begin
        // default fall-through, not taken
        pred_d.taken   = 1'b0;
        pred_d.target  = seq_pc;
        // checkpoint is sp before this fetch moves it
        pred_d.ras_idx = ras_sp;
        if (lookup.hit) begin
            unique case (lookup.kind)
                BR_JUMP, BR_CALL: begin
                    pred_d.taken  = 1'b1;
                    pred_d.target = {lookup.target, 1'b0};
                end
                BR_RET, BR_CORET: begin
                    // old top even if a restore lands now
                    pred_d.taken  = 1'b1;
                    pred_d.target = {ras_top, 1'b0};
                end
                default: begin
                    pred_d.taken = 1'b0;
                end
            endcase
        end
    end

    // ------------------------------
    // stack control
    // ------------------------------

    // link is the return point after the call
    always_comb begin
        ctl.link = seq_pc[31:1];
        ctl.push = fetch_valid && lookup.hit
                && ((lookup.kind == BR_CALL) || (lookup.kind == BR_CORET));
        ctl.pop  = fetch_valid && lookup.hit
                && ((lookup.kind == BR_RET) || (lookup.kind == BR_CORET));
    end

    // ------------------------------
    // output register
    // ------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    // payload only loads with a fetch
    always_ff @(posedge CLK) begin
        if (fetch_valid) begin
            pred <= pred_d;
        end
    end

    // one prediction per fetch, exactly one cycle later
    a_pred_follows_fetch: assert property (@(posedge CLK) disable iff (!nRST)
        pred_valid == $past(fetch_valid));

endmodule

// File: verilog/btb.sv
`timescale 1ns/1ps

`include "bpred_cfg.svh"

module btb (
    input  logic                   CLK,
    input  logic                   nRST,
    // combinational lookup for the fetch side
    input  bpred_pkg::pc_t         lookup_pc,
    output bpred_pkg::btb_lookup_t lookup,
    // training from resolve
    input  logic                   wr_valid,
    input  bpred_pkg::resolve_t    wr
);

    import bpred_pkg::*;

    localparam int ENTRIES = 1 << `BPRED_BTB_IDX_W;
    // tag sits directly above the index bits
    localparam int TAG_LSB = 2 + `BPRED_BTB_IDX_W;

    // ------------------------------
    // pc slicing
    // ------------------------------

    function automatic btb_idx_t idx_of(input pc_t pc);
        return pc[2 +: `BPRED_BTB_IDX_W];
    endfunction

    function automatic btb_tag_t tag_of(input pc_t pc);
        return pc[TAG_LSB +: `BPRED_TAG_W];
    endfunction

    btb_entry_t tbl_q [ENTRIES];
    btb_idx_t   rd_idx;
    btb_idx_t   wr_idx;
    btb_entry_t rd_entry;
    btb_entry_t wr_entry;

    // ------------------------------
    // lookup
    // ------------------------------

    assign rd_idx   = idx_of(lookup_pc);
    assign rd_entry = tbl_q[rd_idx];

    always_comb begin
        lookup.hit = rd_entry.valid
                  && (rd_entry.tag == tag_of(lookup_pc))
                  && (rd_entry.kind != BR_NONE);
        // kind reads as none on a miss
        lookup.kind   = lookup.hit ? rd_entry.kind : BR_NONE;
        lookup.target = rd_entry.target;
    end

    // ------------------------------
    // training
    // ------------------------------

    assign wr_idx = idx_of(wr.pc);

    // kind none clears the slot
    always_comb begin
        wr_entry = '0;
        if (wr.kind != BR_NONE) begin
            wr_entry.valid  = 1'b1;
            wr_entry.tag    = tag_of(wr.pc);
            wr_entry.kind   = wr.kind;
            wr_entry.target = wr.target[31:1];
        end
    end

    // write lands at the edge and is seen by the next fetch only
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tbl_q[i] <= '0;
            end
        end else if (wr_valid) begin
            tbl_q[wr_idx] <= wr_entry;
        end
    end

    // targets are half-word aligned
    a_even_target: assert property (@(posedge CLK) disable iff (!nRST)
        (wr_valid && (wr.kind != BR_NONE)) |-> !wr.target[0]);

endmodule

// File: verilog/ras.sv
`timescale 1ns/1ps

`include "bpred_cfg.svh"

module ras (
    input  logic                  CLK,
    input  logic                  nRST,
    // push / pop from next_pc_sel
    input  bpred_pkg::stack_ctl_t ctl,
    // checkpoint restore from the resolve path
    input  logic                  restore,
    input  bpred_pkg::ras_idx_t   restore_idx,
    // current top and pointer, combinational
    output bpred_pkg::target_t    ras_top,
    output bpred_pkg::ras_idx_t   ras_sp
);

    import bpred_pkg::*;

    // ------------------------------
    // storage
    // ------------------------------

    // circular, oldest entry overwritten on wrap
    target_t  stack_q [`BPRED_RAS_ENTRIES];
    ras_idx_t sp_q;

    // neighbours of sp, wrap at ras_idx_t width
    ras_idx_t sp_inc;
    ras_idx_t sp_dec;

    assign sp_inc = sp_q + 1'b1;
    assign sp_dec = sp_q - 1'b1;

    // ------------------------------
    // update
    // ------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sp_q <= '0;
            for (int i = 0; i < `BPRED_RAS_ENTRIES; i++) begin
                stack_q[i] <= '0;
            end
        end else if (restore) begin
            // mispredict wins, fetch change dropped
            sp_q <= restore_idx;
        end else if (ctl.push && ctl.pop) begin
            // coret replaces top, sp unchanged
            stack_q[sp_q] <= ctl.link;
        end else if (ctl.push) begin
            // link goes one above current top
            stack_q[sp_inc] <= ctl.link;
            sp_q            <= sp_inc;
        end else if (ctl.pop) begin
            // entry stays, only pointer moves
            sp_q <= sp_dec;
        end
    end

    // ------------------------------
    // read
    // ------------------------------

    assign ras_top = stack_q[sp_q];
    assign ras_sp  = sp_q;

    // pointer lands on the checkpoint one cycle after a restore
    a_restore_sp: assert property (@(posedge CLK) disable iff (!nRST)
        restore |=> (ras_sp == $past(restore_idx)));

endmodule

// File: verilog/bpred_pkg.sv
`include "bpred_cfg.svh"

package bpred_pkg;

    // ------------------------------
    // plain widths
    // ------------------------------

    typedef logic [31:0] pc_t;
    // half-word aligned, bit 0 dropped
    typedef logic [30:0] target_t;
    typedef logic [`BPRED_RAS_IDX_W-1:0] ras_idx_t;
    typedef logic [`BPRED_BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [`BPRED_TAG_W-1:0] btb_tag_t;

    // branch kind as stored in the btb
    // coret is a call that also returns
    typedef enum logic [2:0] {
        BR_NONE  = 3'd0,
        BR_JUMP  = 3'd1,
        BR_CALL  = 3'd2,
        BR_RET   = 3'd3,
        BR_CORET = 3'd4
    } br_kind_e;

    // ------------------------------
    // bundles
    // ------------------------------

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        br_kind_e kind;
        target_t  target;
    } btb_entry_t;

    typedef struct packed {
        logic     hit;
        br_kind_e kind;
        target_t  target;
    } btb_lookup_t;

    // push and pop together replace the top
    typedef struct packed {
        logic    push;
        logic    pop;
        target_t link;
    } stack_ctl_t;

    // ras_idx is the pointer before this fetch's update
    typedef struct packed {
        logic     taken;
        pc_t      target;
        ras_idx_t ras_idx;
    } pred_t;

    typedef struct packed {
        pc_t      pc;
        pc_t      target;
        br_kind_e kind;
        logic     mispredict;
        ras_idx_t ras_idx;
    } resolve_t;

endpackage

// File: verilog/bpred_cfg.svh
`ifndef BPRED_CFG_SVH
`define BPRED_CFG_SVH

// ------------------------------
// return address stack
// ------------------------------

// stack depth, one entry per pointer value
`define BPRED_RAS_ENTRIES 8
// pointer width, wraps at depth
`define BPRED_RAS_IDX_W 3

// ------------------------------
// branch target buffer
// ------------------------------

// index bits, pc[5:2] for 16 entries
`define BPRED_BTB_IDX_W 4
// tag bits, pc just above the index
`define BPRED_TAG_W 8

`endif
